// File: Makefile
VERILATOR ?= verilator
TOP ?= trellisDemodTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/demodPatterns.txt
// columns: i0 q0 i1 q1 (12-bit hex), decision, metricDiff (8-bit hex), tone0, tone1 (18-bit hex)
// rows go in groups of six, one DAC select setting per group
064 000 000 064 0 EA 00578 00000
064 000 000 F9C 1 15 00000 00578
032 01E 000 000 0 00 00230 00230
7D0 000 000 830 1 7F 00000 06D60
830 000 000 830 0 81 06D60 00000
002 000 000 001 0 FF 00015 00007
002 000 000 FFF 1 00 00007 00015
ED4 190 096 FCE 1 15 01068 015E0
3E8 CE0 DA8 384 0 BE 0396C 02904
A24 A24 5DC 5DC 0 00 05208 05208
7FF 7FF 7FF 800 1 7F 00007 0DFEB
800 800 7FF 800 0 81 0DFF9 00007
005 FFD 008 FFA 1 00 00054 00070
000 246 246 000 1 7F 00000 01FD4
000 23F DC1 000 0 82 01F72 00000
D44 12C F06 190 1 20 0173E 01F72
07B EBF 04D F9D 1 04 00B8A 00CBE
FCE FC4 046 FB0 0 E7 0071C 00118
12C 0C8 F9C 258 0 A8 020D0 00AF0
000 000 000 000 0 00 00000 00000
FA6 02D 02D 05A 1 1D 00000 00762
457 F22 14D E44 1 30 0216A 02D8E
000 FFB FFB 000 1 01 00000 00046
000 005 FFB 000 0 FE 00046 00000

// File: bench/trellisDemodTb.sv
// Simulation top that replays the pattern file into the demodulator and checks every output.
`timescale 1ns/100ps

module trellisDemodTb
  import trellisPkg::*;
();

  localparam int NUM_PATTERNS = 24;
  localparam int FIELDS = 8;
  localparam int GROUP_SIZE = 6;
  localparam int CYCLE_LIMIT = 40 * NUM_PATTERNS + 50;
  localparam logic [1:0] DAC0_ORDER [4] = '{
    DAC_SEL_DIFF, DAC_SEL_TONE1, DAC_SEL_INPUT_I, DAC_SEL_TONE0
  };
  localparam logic [1:0] DAC1_ORDER [4] = '{
    DAC_SEL_TONE0, DAC_SEL_INPUT_I, DAC_SEL_DIFF, DAC_SEL_TONE1
  };

  logic                          clk;
  logic                          reset;
  logic                          sampleReq;
  logic                          sampleAck;
  logic signed [SAMPLE_BITS-1:0] sampleI;
  logic signed [SAMPLE_BITS-1:0] sampleQ;
  logic                          decReq;
  logic                          decAck;
  logic                          decision;
  logic signed [DIFF_BITS-1:0]   metricDiff;
  logic [1:0]                    dac0Select;
  logic [1:0]                    dac1Select;
  logic                          dac0Sync;
  logic [DAC_BITS-1:0]           dac0Data;
  logic                          dac1Sync;
  logic [DAC_BITS-1:0]           dac1Data;

  // eight words per pattern in file column order.
  logic [31:0] patMem [NUM_PATTERNS*FIELDS];
  logic [31:0] rngState = 32'ha1ac_0bd1;
  int          decCount = 0;
  int          dacCount = 0;
  int          cycleCount = 0;

  trellisDemod uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] patternField(input int p, input int f);
    return patMem[p * FIELDS + f];
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // monitor word a select code picks for one pattern.
  function automatic logic [31:0] expectedDacWord(input int p, input logic [1:0] sel);
    logic [DIFF_BITS-1:0]   diff;
    logic [SAMPLE_BITS-1:0] firstI;
    logic [DAC_BITS-1:0]    word;
    diff = patMem[p * FIELDS + 5][DIFF_BITS-1:0];
    firstI = patMem[p * FIELDS][SAMPLE_BITS-1:0];
    case (sel)
      DAC_SEL_DIFF: word = {diff, {(DAC_BITS - DIFF_BITS){1'b0}}};
      DAC_SEL_TONE0: word = patMem[p * FIELDS + 6][DAC_BITS-1:0];
      DAC_SEL_TONE1: word = patMem[p * FIELDS + 7][DAC_BITS-1:0];
      default: word = {{(DAC_BITS - SAMPLE_BITS){firstI[SAMPLE_BITS-1]}}, firstI};
    endcase
    return {{(32 - DAC_BITS){1'b0}}, word};
  endfunction

  // one full four-phase transfer that needs ack idle before req rises.
  task automatic sendSample(input logic [31:0] i, input logic [31:0] q);
    @(posedge clk);
    checkValue("sampleAck", {31'd0, sampleAck}, 32'd0);
    sampleReq <= 1'b1;
    sampleI <= i[SAMPLE_BITS-1:0];
    sampleQ <= q[SAMPLE_BITS-1:0];
    @(posedge clk);
    while (!sampleAck) @(posedge clk);
    sampleReq <= 1'b0;
    @(posedge clk);
    while (sampleAck) @(posedge clk);
  endtask

  initial begin
    reset = 1'b1;
    sampleReq = 1'b0;
    sampleI = '0;
    sampleQ = '0;
    dac0Select = DAC0_ORDER[0];
    dac1Select = DAC1_ORDER[0];
    $readmemh("bench/demodPatterns.txt", patMem);
    if (^patMem[NUM_PATTERNS * FIELDS - 1] === 1'bx) begin
      stopWithFailure("pattern file is missing or has too few entries");
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    checkValue("sampleAck", {31'd0, sampleAck}, 32'd0);
    checkValue("decReq", {31'd0, decReq}, 32'd0);
    checkValue("dac0Sync", {31'd0, dac0Sync}, 32'd0);
    checkValue("dac1Sync", {31'd0, dac1Sync}, 32'd0);
    checkValue("dac0Data", {14'd0, dac0Data}, 32'd0);
    checkValue("dac1Data", {14'd0, dac1Data}, 32'd0);
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      if (p % GROUP_SIZE == 0) begin
        // drain the previous group before the selects move.
        while (decCount < p) @(posedge clk);
        dac0Select <= DAC0_ORDER[p / GROUP_SIZE];
        dac1Select <= DAC1_ORDER[p / GROUP_SIZE];
      end
      sendSample(patternField(p, 0), patternField(p, 1));
      sendSample(patternField(p, 2), patternField(p, 3));
    end
    while (decCount < NUM_PATTERNS || dacCount < NUM_PATTERNS) @(posedge clk);
    // quiet time so a repeated decision or sync shows up.
    repeat (20) @(posedge clk);
    $display("TEST OK");
    $finish;
  end

  // decision sink with random ack delay.
  initial begin
    decAck = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && decReq) begin
        if (decCount >= NUM_PATTERNS) begin
          stopWithFailure("decision request arrived after the last pattern");
        end
        checkValue("decision", {31'd0, decision}, patternField(decCount, 4));
        checkValue("metricDiff", {24'd0, metricDiff}, patternField(decCount, 5));
        rngState = xorshift32(rngState);
        repeat (rngState[2:0]) @(posedge clk);
        decAck <= 1'b1;
        decCount <= decCount + 1;
        @(posedge clk);
        while (decReq) @(posedge clk);
        decAck <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && (dac0Sync || dac1Sync)) begin
      if (dacCount >= NUM_PATTERNS) begin
        stopWithFailure("DAC sync pulse arrived after the last pattern");
      end
      checkValue("dac0Sync", {31'd0, dac0Sync}, 32'd1);
      checkValue("dac1Sync", {31'd0, dac1Sync}, 32'd1);
      checkValue("dac0Data", {14'd0, dac0Data}, expectedDacWord(dacCount, dac0Select));
      checkValue("dac1Data", {14'd0, dac1Data}, expectedDacWord(dacCount, dac1Select));
      dacCount <= dacCount + 1;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      stopWithFailure($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

endmodule

// File: design/dacSelector.sv
// Two registered DAC monitor channels, each picking one result word per accepted symbol.
`timescale 1ns/100ps

module dacSelector
  import trellisPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [1:0]          dac0Select,
  input  logic [1:0]          dac1Select,
  resultBus.sink              rb,
  output logic                dac0Sync,
  output logic [DAC_BITS-1:0] dac0Data,
  output logic                dac1Sync,
  output logic [DAC_BITS-1:0] dac1Data
);

  logic [DAC_BITS-1:0] monWord [4];

  // difference sits in the top bits.
  assign monWord[DAC_SEL_DIFF] = {rb.metricDiff, {(DAC_BITS - DIFF_BITS){1'b0}}};
  assign monWord[DAC_SEL_TONE0] = rb.tone0Metric;
  assign monWord[DAC_SEL_TONE1] = rb.tone1Metric;
  assign monWord[DAC_SEL_INPUT_I] = {{(DAC_BITS - SAMPLE_BITS){rb.i0[SAMPLE_BITS-1]}}, rb.i0};

  always_ff @(posedge clk) begin
    if (reset) begin
      dac0Sync <= 1'b0;
      dac1Sync <= 1'b0;
      dac0Data <= '0;
      dac1Data <= '0;
    end else begin
      dac0Sync <= rb.strobe;
      dac1Sync <= rb.strobe;
      if (rb.strobe) begin
        dac0Data <= monWord[dac0Select];
        dac1Data <= monWord[dac1Select];
      end
    end
  end

endmodule

// File: design/demodBus.sv
// Internal links between the demodulator blocks: symbol, metric and result buses.
`timescale 1ns/100ps

// one complete two-sample symbol, valid/ready.
interface sampleBus
  import trellisPkg::*;
();
  logic valid;
  logic ready;
  logic signed [SAMPLE_BITS-1:0] i0;
  logic signed [SAMPLE_BITS-1:0] q0;
  logic signed [SAMPLE_BITS-1:0] i1;
  logic signed [SAMPLE_BITS-1:0] q1;

  modport source(output valid, i0, q0, i1, q1, input ready);
  modport sink(input valid, i0, q0, i1, q1, output ready);
endinterface

// both tone metrics of a symbol, valid/ready.
interface metricBus
  import trellisPkg::*;
();
  logic valid;
  logic ready;
  logic [METRIC_BITS-1:0] tone0Metric;
  logic [METRIC_BITS-1:0] tone1Metric;
  logic signed [SAMPLE_BITS-1:0] i0;

  modport source(output valid, tone0Metric, tone1Metric, i0, input ready);
  modport sink(input valid, tone0Metric, tone1Metric, i0, output ready);
endinterface

// one-cycle strobe per accepted symbol, for monitoring.
interface resultBus
  import trellisPkg::*;
();
  logic strobe;
  logic signed [DIFF_BITS-1:0] metricDiff;
  logic [METRIC_BITS-1:0] tone0Metric;
  logic [METRIC_BITS-1:0] tone1Metric;
  logic signed [SAMPLE_BITS-1:0] i0;

  modport source(output strobe, metricDiff, tone0Metric, tone1Metric, i0);
  modport sink(input strobe, metricDiff, tone0Metric, tone1Metric, i0);
endinterface

// File: design/symbolCapture.sv
// Four-phase I/Q sample receiver that pairs consecutive samples into symbols for the correlator.
`timescale 1ns/100ps

module symbolCapture
  import trellisPkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sampleReq,
  input  logic signed [SAMPLE_BITS-1:0] sampleI,
  input  logic signed [SAMPLE_BITS-1:0] sampleQ,
  output logic                          sampleAck,
  sampleBus.source                      sb
);

  logic                          secondHalf;
  logic                          holdFull;
  logic                          capture;
  logic signed [SAMPLE_BITS-1:0] firstI;
  logic signed [SAMPLE_BITS-1:0] firstQ;

  // symbol register still owned by the correlator.
  assign holdFull = sb.valid && !sb.ready;

  // a first sample waits until the symbol register frees up.
  assign capture = sampleReq && !sampleAck && (secondHalf || !holdFull);

  always_ff @(posedge clk) begin
    if (reset) begin
      sampleAck <= 1'b0;
      secondHalf <= 1'b0;
      sb.valid <= 1'b0;
    end else begin
      if (sb.valid && sb.ready) begin
        sb.valid <= 1'b0;
      end
      if (capture) begin
        sampleAck <= 1'b1;
        secondHalf <= !secondHalf;
        if (secondHalf) begin
          sb.valid <= 1'b1;
        end
      end else if (sampleAck && !sampleReq) begin
        // source dropped req, close the handshake.
        sampleAck <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      if (!secondHalf) begin
        firstI <= sampleI;
        firstQ <= sampleQ;
      end else begin
        sb.i0 <= firstI;
        sb.q0 <= firstQ;
        sb.i1 <= sampleI;
        sb.q1 <= sampleQ;
      end
    end
  end

endmodule

// File: design/symbolSlicer.sv
// Tone decision and scaled metric difference, delivered over a four-phase output handshake.
`timescale 1ns/100ps

module symbolSlicer
  import trellisPkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        decAck,
  output logic                        decReq,
  output logic                        decision,
  output logic signed [DIFF_BITS-1:0] metricDiff,
  metricBus.sink                      mb,
  resultBus.source                    rb
);

  logic                          loaded;
  logic                          accept;
  logic signed [METRIC_BITS:0]   rawDiff;
  logic signed [METRIC_BITS:0]   shiftDiff;
  logic signed [DIFF_BITS-1:0]   satDiff;

  // only take a symbol when the output handshake is fully idle.
  assign mb.ready = !loaded && !decReq && !decAck;
  assign accept = mb.valid && mb.ready;

  always_comb begin
    rawDiff = $signed({1'b0, mb.tone1Metric}) - $signed({1'b0, mb.tone0Metric});
    shiftDiff = rawDiff >>> DIFF_SHIFT;
    if (shiftDiff > DIFF_MAX) begin
      satDiff = DIFF_BITS'(DIFF_MAX);
    end else if (shiftDiff < -DIFF_MAX) begin
      satDiff = DIFF_BITS'(-DIFF_MAX);
    end else begin
      satDiff = shiftDiff[DIFF_BITS-1:0];
    end
  end

  // monitor copy of the accepted symbol.
  assign rb.strobe = accept;
  assign rb.metricDiff = satDiff;
  assign rb.tone0Metric = mb.tone0Metric;
  assign rb.tone1Metric = mb.tone1Metric;
  assign rb.i0 = mb.i0;

  always_ff @(posedge clk) begin
    if (reset) begin
      loaded <= 1'b0;
      decReq <= 1'b0;
    end else begin
      loaded <= accept;
      if (loaded) begin
        decReq <= 1'b1;
      end else if (decReq && decAck) begin
        decReq <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      // ties go to tone 0.
      decision <= mb.tone1Metric > mb.tone0Metric;
      metricDiff <= satDiff;
    end
  end

endmodule

// File: design/toneCorrelator.sv
// Two-stage stallable correlator computing the tone 0 and tone 1 magnitude metrics per symbol.
`timescale 1ns/100ps

module toneCorrelator
  import trellisPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  sampleBus.sink   sb,
  metricBus.source mb
);

  logic                          s1Valid;
  logic                          outMove;
  logic                          s1Move;
  logic signed [PART_BITS-1:0]   s1Re [2][2];
  logic signed [PART_BITS-1:0]   s1Im [2][2];
  logic signed [SAMPLE_BITS-1:0] s1I0;
  logic signed [CORR_BITS-1:0]   corrRe [2];
  logic signed [CORR_BITS-1:0]   corrIm [2];
  logic [METRIC_BITS-1:0]        metric [2];

  function automatic logic signed [COEF_BITS-1:0] coef(input int tone, input int idx);
    return (tone == 1) ? TONE1_COEF[idx] : TONE0_COEF[idx];
  endfunction

  // i*cr + q*ci for one sample.
  function automatic logic signed [PART_BITS-1:0] partReal(
    input logic signed [SAMPLE_BITS-1:0] i,
    input logic signed [SAMPLE_BITS-1:0] q,
    input logic signed [COEF_BITS-1:0]   cr,
    input logic signed [COEF_BITS-1:0]   ci
  );
    logic signed [PART_BITS-1:0] a;
    logic signed [PART_BITS-1:0] b;
    a = i * cr;
    b = q * ci;
    return a + b;
  endfunction

  // q*cr - i*ci for one sample.
  function automatic logic signed [PART_BITS-1:0] partImag(
    input logic signed [SAMPLE_BITS-1:0] i,
    input logic signed [SAMPLE_BITS-1:0] q,
    input logic signed [COEF_BITS-1:0]   cr,
    input logic signed [COEF_BITS-1:0]   ci
  );
    logic signed [PART_BITS-1:0] a;
    logic signed [PART_BITS-1:0] b;
    a = q * cr;
    b = i * ci;
    return a - b;
  endfunction

  function automatic logic [METRIC_BITS-1:0] absVal(input logic signed [CORR_BITS-1:0] x);
    return x[CORR_BITS-1] ? METRIC_BITS'(-x) : METRIC_BITS'(x);
  endfunction

  // each stage moves when the one ahead is empty or draining.
  assign outMove = !mb.valid || mb.ready;
  assign s1Move = !s1Valid || outMove;
  assign sb.ready = s1Move;

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      corrRe[t] = s1Re[t][0] + s1Re[t][1];
      corrIm[t] = s1Im[t][0] + s1Im[t][1];
      metric[t] = absVal(corrRe[t]) + absVal(corrIm[t]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1Valid <= 1'b0;
      mb.valid <= 1'b0;
    end else begin
      if (s1Move) begin
        s1Valid <= sb.valid;
      end
      if (outMove) begin
        mb.valid <= s1Valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1Move && sb.valid) begin
      for (int t = 0; t < 2; t++) begin
        s1Re[t][0] <= partReal(sb.i0, sb.q0, coef(t, 0), coef(t, 1));
        s1Im[t][0] <= partImag(sb.i0, sb.q0, coef(t, 0), coef(t, 1));
        s1Re[t][1] <= partReal(sb.i1, sb.q1, coef(t, 2), coef(t, 3));
        s1Im[t][1] <= partImag(sb.i1, sb.q1, coef(t, 2), coef(t, 3));
      end
      s1I0 <= sb.i0;
    end
    if (outMove && s1Valid) begin
      mb.tone0Metric <= metric[0];
      mb.tone1Metric <= metric[1];
      mb.i0 <= s1I0;
    end
  end

endmodule

// File: design/trellisDemod.sv
// Demodulator top level wiring capture, correlator, slicer and DAC monitor through internal buses.
`timescale 1ns/100ps

module trellisDemod
  import trellisPkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sampleReq,
  output logic                          sampleAck,
  input  logic signed [SAMPLE_BITS-1:0] sampleI,
  input  logic signed [SAMPLE_BITS-1:0] sampleQ,
  output logic                          decReq,
  input  logic                          decAck,
  output logic                          decision,
  output logic signed [DIFF_BITS-1:0]   metricDiff,
  input  logic [1:0]                    dac0Select,
  input  logic [1:0]                    dac1Select,
  output logic                          dac0Sync,
  output logic [DAC_BITS-1:0]           dac0Data,
  output logic                          dac1Sync,
  output logic [DAC_BITS-1:0]           dac1Data
);

  sampleBus symbolLink();
  metricBus metricLink();
  resultBus resultLink();

  symbolCapture capture (
    .clk(clk),
    .reset(reset),
    .sampleReq(sampleReq),
    .sampleI(sampleI),
    .sampleQ(sampleQ),
    .sampleAck(sampleAck),
    .sb(symbolLink.source)
  );

  toneCorrelator correlator (
    .clk(clk),
    .reset(reset),
    .sb(symbolLink.sink),
    .mb(metricLink.source)
  );

  symbolSlicer slicer (
    .clk(clk),
    .reset(reset),
    .decAck(decAck),
    .decReq(decReq),
    .decision(decision),
    .metricDiff(metricDiff),
    .mb(metricLink.sink),
    .rb(resultLink.source)
  );

  // monitor taps on every accepted symbol.
  dacSelector dacMux (
    .clk(clk),
    .reset(reset),
    .dac0Select(dac0Select),
    .dac1Select(dac1Select),
    .rb(resultLink.sink),
    .dac0Sync(dac0Sync),
    .dac0Data(dac0Data),
    .dac1Sync(dac1Sync),
    .dac1Data(dac1Data)
  );

endmodule

// File: design/trellisPkg.sv
// Shared widths, tone coefficients and DAC select codes, imported by every demodulator block.
package trellisPkg;

  // sample and coefficient widths.
  localparam int SAMPLE_BITS = 12;
  localparam int COEF_BITS = 4;

  // per-sample partial sum and full two-sample correlation widths.
  localparam int PART_BITS = SAMPLE_BITS + COEF_BITS + 1;
  localparam int CORR_BITS = PART_BITS + 1;

  // |re| + |im| of the correlation.
  localparam int METRIC_BITS = 18;

  // scaled tone1 - tone0 difference.
  localparam int DIFF_BITS = 8;
  localparam int DIFF_SHIFT = 6;
  localparam int DIFF_MAX = 2 ** (DIFF_BITS - 1) - 1;

  localparam int DAC_BITS = 18;

  // order is sample 0 real, sample 0 imag, sample 1 real, sample 1 imag.
  localparam logic signed [COEF_BITS-1:0] TONE0_COEF [4] = '{
    4'sd7, 4'sd0, 4'sd0, 4'sd7
  };
  localparam logic signed [COEF_BITS-1:0] TONE1_COEF [4] = '{
    4'sd7, 4'sd0, 4'sd0, -4'sd7
  };

  // monitor word choices for the DAC channels.
  localparam logic [1:0] DAC_SEL_DIFF = 2'd0;
  localparam logic [1:0] DAC_SEL_TONE0 = 2'd1;
  localparam logic [1:0] DAC_SEL_TONE1 = 2'd2;
  localparam logic [1:0] DAC_SEL_INPUT_I = 2'd3;

endpackage

// File: sources.f
design/trellisPkg.sv
design/demodBus.sv
design/symbolCapture.sv
design/toneCorrelator.sv
design/symbolSlicer.sv
design/dacSelector.sv
design/trellisDemod.sv
bench/trellisDemodTb.sv
